// ==== l1d_cache_pkg.sv ====
// Cache geometry constants, access size encoding and the address union
// shared by the L1 data cache blocks
`default_nettype none

package l1d_cache_pkg;

  // ==========================================================================
  // Geometry
  // ==========================================================================
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int INDEX_W    = 6;
  localparam int OFFSET_W   = 4;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

  // Derived widths
  localparam int NUM_LINES = 1 << INDEX_W;
  localparam int BE_W      = DATA_W / 8;
  localparam int LANE_W    = 2;
  localparam int WSEL_W    = OFFSET_W - LANE_W;

  // ==========================================================================
  // Access size on core and memory ports
  // ==========================================================================
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_e;

  // Address fields, most significant first
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WSEL_W-1:0]  wsel;
    logic [LANE_W-1:0]  lane;
  } cache_addr_s;

  // Same address seen as a raw word or split into fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    cache_addr_s       f;
  } cache_addr_u;

endpackage

`default_nettype wire

// ==== bank_if.sv ====
// Connection from the controller to one word bank, with the lookup tap
`timescale 1ns/1ps
`default_nettype none

interface bank_if import l1d_cache_pkg::*; ();

  logic [INDEX_W-1:0] index;
  logic               rd_en;
  // This bank's bit of the write-enable vector
  logic               we;
  logic [BE_W-1:0]    be;
  logic [DATA_W-1:0]  wdata;
  logic [DATA_W-1:0]  rdata;
  // Latched word select for the hit mux
  logic [WSEL_W-1:0]  word_sel;

  modport ctrl (
    output index, rd_en, we, be, wdata, word_sel
  );

  modport bank (
    input  index, rd_en, we, be, wdata,
    output rdata
  );

  modport lookup (
    input index, rd_en, rdata, word_sel
  );

endinterface

`default_nettype wire

// ==== l1d_ctrl.sv ====
// Cache controller FSM covering lookup, four-word line fill and
// write-through with write-hit update of the data banks
`timescale 1ns/1ps
`default_nettype none

module l1d_ctrl import l1d_cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // Core side
  input  logic               core_req,
  input  logic [ADDR_W-1:0]  core_addr,
  input  logic               core_write,
  input  logic [DATA_W-1:0]  core_wdata,
  input  access_size_e       core_size,
  output logic               core_wait,
  output logic [DATA_W-1:0]  core_rdata,
  // Memory side
  input  logic [DATA_W-1:0]  mem_rdata,
  input  logic               mem_wait,
  output logic               mem_req,
  output logic [ADDR_W-1:0]  mem_addr,
  output logic               mem_write,
  output logic [DATA_W-1:0]  mem_wdata,
  output access_size_e       mem_size,
  // Lookup results and tag update
  input  logic               hit,
  input  logic [DATA_W-1:0]  hit_word,
  output logic [TAG_W-1:0]   fill_tag,
  output logic               fill_valid,
  // Word banks
  bank_if.ctrl               bank [LINE_WORDS]
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_FILL_REQ,
    S_FILL_WAIT,
    S_FILL_WRITE,
    S_WR_REQ,
    S_WR_WAIT
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic [WSEL_W-1:0]   fill_cnt;

  // Latched request
  cache_addr_u         req;
  logic                req_write;
  logic [DATA_W-1:0]   req_wdata;
  access_size_e        req_size;

  cache_addr_u         core_a;
  cache_addr_u         fill_addr;
  logic [DATA_W-1:0]   line_buf [LINE_WORDS];
  logic                fill_done;
  logic                bank_rd_en;
  logic [INDEX_W-1:0]  bank_index;
  logic                wr_hit;
  logic [LANE_W-1:0]   wr_lane;
  logic [BE_W-1:0]     wr_be;
  logic [DATA_W-1:0]   wr_data;

  assign core_a.raw = core_addr;
  assign fill_done  = (state_q == S_FILL_WAIT) && !mem_wait;

  // ==========================================================================
  // State machine
  // ==========================================================================
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
      begin
        if (core_req)
          state_d = S_LOOKUP;
      end
      S_LOOKUP:
      begin
        if (req_write)
          state_d = S_WR_REQ;
        else if (hit)
          state_d = S_IDLE;
        else
          state_d = S_FILL_REQ;
      end
      S_FILL_REQ:
        state_d = S_FILL_WAIT;
      S_FILL_WAIT:
      begin
        if (!mem_wait)
          state_d = (fill_cnt == '1) ? S_FILL_WRITE : S_FILL_REQ;
      end
      S_FILL_WRITE:
        state_d = S_IDLE;
      S_WR_REQ:
        state_d = S_WR_WAIT;
      S_WR_WAIT:
      begin
        if (!mem_wait)
          state_d = S_IDLE;
      end
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q  <= S_IDLE;
      fill_cnt <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == S_LOOKUP)
        fill_cnt <= '0;
      else if (fill_done)
        fill_cnt <= fill_cnt + 1'b1;
    end
  end

  // Request capture, fill buffer and read data
  always_ff @(posedge clk)
  begin
    if (state_q == S_IDLE && core_req)
    begin
      req.raw   <= core_addr;
      req_write <= core_write;
      req_wdata <= core_wdata;
      req_size  <= core_size;
    end
    if (state_q == S_LOOKUP && !req_write && hit)
      core_rdata <= hit_word;
    if (fill_done)
      line_buf[fill_cnt] <= mem_rdata;
    // Requested word goes back when the line is complete
    if (state_q == S_FILL_WRITE)
      core_rdata <= line_buf[req.f.wsel];
  end

  // ==========================================================================
  // Memory port
  // ==========================================================================
  always_comb
  begin
    fill_addr        = req;
    fill_addr.f.wsel = fill_cnt;
    fill_addr.f.lane = '0;
  end

  assign core_wait = (state_q != S_IDLE);
  assign mem_req   = (state_q == S_FILL_REQ) || (state_q == S_WR_REQ);
  assign mem_write = (state_q == S_WR_REQ) || (state_q == S_WR_WAIT);
  assign mem_addr  = mem_write ? req.raw : fill_addr.raw;
  // Store data goes out unshifted, aligned by address and size
  assign mem_wdata = req_wdata;
  assign mem_size  = mem_write ? req_size : SIZE_WORD;

  // ==========================================================================
  // Bank and tag control
  // ==========================================================================
  assign bank_rd_en = (state_q == S_IDLE) && core_req;
  assign bank_index = bank_rd_en ? core_a.f.index : req.f.index;
  assign wr_hit     = (state_q == S_LOOKUP) && req_write && hit;
  assign fill_tag   = req.f.tag;
  assign fill_valid = (state_q == S_FILL_WRITE);

  // Byte lane and enables for a write hit
  always_comb
  begin
    case (req_size)
      SIZE_BYTE:
      begin
        wr_lane = req.f.lane;
        wr_be   = BE_W'(1) << wr_lane;
      end
      SIZE_HALF:
      begin
        wr_lane = {req.f.lane[1], 1'b0};
        wr_be   = BE_W'(3) << wr_lane;
      end
      default:
      begin
        wr_lane = '0;
        wr_be   = '1;
      end
    endcase
  end

  assign wr_data = req_wdata << {wr_lane, 3'b000};

  for (genvar g = 0; g < LINE_WORDS; g++)
  begin : g_bank_drive
    assign bank[g].index    = bank_index;
    assign bank[g].rd_en    = bank_rd_en;
    assign bank[g].word_sel = req.f.wsel;
    assign bank[g].we       = fill_valid || (wr_hit && req.f.wsel == WSEL_W'(g));
    assign bank[g].be       = fill_valid ? '1 : wr_be;
    assign bank[g].wdata    = fill_valid ? line_buf[g] : wr_data;
  end

  // One-cycle request pulse per transfer
  assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req);

endmodule

`default_nettype wire

// ==== l1d_word_bank.sv ====
// One word column of the data array with byte-masked write
`timescale 1ns/1ps
`default_nettype none

module l1d_word_bank import l1d_cache_pkg::*; (
  input  logic clk,
  input  logic rst,
  bank_if.bank bank
);

  logic [DATA_W-1:0] mem [NUM_LINES];

  // Masked write, registered read
  always_ff @(posedge clk)
  begin
    if (bank.we)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (bank.be[b])
          mem[bank.index][b*8 +: 8] <= bank.wdata[b*8 +: 8];
      end
    end
    if (bank.rd_en)
      bank.rdata <= mem[bank.index];
  end

  // Controller never overlaps a lookup read with a fill or store
  assert property (@(posedge clk) disable iff (rst) !(bank.we && bank.rd_en));

endmodule

`default_nettype wire

// ==== l1d_lookup.sv ====
// Tag and valid store, hit compare and selection of the hit word
// from the registered bank outputs
`timescale 1ns/1ps
`default_nettype none

module l1d_lookup import l1d_cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [TAG_W-1:0]   fill_tag,
  input  logic               fill_valid,
  bank_if.lookup             bank [LINE_WORDS],
  output logic               hit,
  output logic [DATA_W-1:0]  hit_word
);

  logic [TAG_W-1:0]   tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [TAG_W-1:0]   tag_q;
  logic               valid_q;
  logic [INDEX_W-1:0] index;
  logic               rd_en;
  logic [WSEL_W-1:0]  word_sel;
  logic [DATA_W-1:0]  line_words [LINE_WORDS];

  // All banks share index, enable and word select
  assign index    = bank[0].index;
  assign rd_en    = bank[0].rd_en;
  assign word_sel = bank[0].word_sel;

  // ==========================================================================
  // Tag store
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (fill_valid)
      tags[index] <= fill_tag;
    if (rd_en)
      tag_q <= tags[index];
  end

  // Valid bits
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (fill_valid)
        valid[index] <= 1'b1;
      if (rd_en)
        valid_q <= valid[index];
    end
  end

  // ==========================================================================
  // Hit compare and word select
  // ==========================================================================
  for (genvar g = 0; g < LINE_WORDS; g++)
  begin : g_line
    assign line_words[g] = bank[g].rdata;
  end

  // Compared against the tag latched in the controller
  assign hit      = valid_q && (tag_q == fill_tag);
  assign hit_word = line_words[word_sel];

  // Tag write and tag read never share a cycle
  assert property (@(posedge clk) disable iff (rst) fill_valid |-> !rd_en);

endmodule

`default_nettype wire

// ==== l1d_cache.sv ====
// L1 data cache top level with core and memory ports, the controller,
// the tag lookup and the word banks
`timescale 1ns/1ps
`default_nettype none

module l1d_cache import l1d_cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // Core side
  input  logic               core_req,
  input  logic [ADDR_W-1:0]  core_addr,
  input  logic               core_write,
  input  logic [DATA_W-1:0]  core_wdata,
  input  access_size_e       core_size,
  output logic               core_wait,
  output logic [DATA_W-1:0]  core_rdata,
  // Memory side
  input  logic [DATA_W-1:0]  mem_rdata,
  input  logic               mem_wait,
  output logic               mem_req,
  output logic [ADDR_W-1:0]  mem_addr,
  output logic               mem_write,
  output logic [DATA_W-1:0]  mem_wdata,
  output access_size_e       mem_size
);

  logic              hit;
  logic [DATA_W-1:0] hit_word;
  logic [TAG_W-1:0]  fill_tag;
  logic              fill_valid;

  // One connection per word bank
  bank_if bank_bus [LINE_WORDS] ();

  l1d_ctrl ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_addr  (core_addr),
    .core_write (core_write),
    .core_wdata (core_wdata),
    .core_size  (core_size),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_write  (mem_write),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .hit        (hit),
    .hit_word   (hit_word),
    .fill_tag   (fill_tag),
    .fill_valid (fill_valid),
    .bank       (bank_bus)
  );

  l1d_lookup lookup_inst (
    .clk        (clk),
    .rst        (rst),
    .fill_tag   (fill_tag),
    .fill_valid (fill_valid),
    .bank       (bank_bus),
    .hit        (hit),
    .hit_word   (hit_word)
  );

  // ==========================================================================
  // Data array, one bank per word of the line
  // ==========================================================================
  for (genvar g = 0; g < LINE_WORDS; g++)
  begin : g_bank
    l1d_word_bank bank_inst (
      .clk  (clk),
      .rst  (rst),
      .bank (bank_bus[g])
    );
  end

endmodule

`default_nettype wire

// ==== l1d_checker.sv ====
// Reference model of memory and resident tags, and the process that
// compares the cache ports against it
`timescale 1ns/1ps
`default_nettype none

module l1d_checker import l1d_cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              core_req,
  input  logic [ADDR_W-1:0] core_addr,
  input  logic              core_write,
  input  logic [DATA_W-1:0] core_wdata,
  input  access_size_e      core_size,
  input  logic              core_wait,
  input  logic [DATA_W-1:0] core_rdata,
  input  logic              mem_req,
  input  logic [ADDR_W-1:0] mem_addr,
  input  logic              mem_write,
  input  logic [DATA_W-1:0] mem_wdata,
  input  access_size_e      mem_size,
  output int                errors,
  output int                checks,
  output int                ops_done
);

  localparam int MEM_WORDS = 1024;

  logic [DATA_W-1:0]    ref_mem [MEM_WORDS];
  logic [TAG_W-1:0]     ref_tag [NUM_LINES];
  logic [NUM_LINES-1:0] ref_valid;

  // Access in progress
  logic              busy;
  logic              after_reset;
  logic [ADDR_W-1:0] op_addr;
  logic              op_write;
  logic [DATA_W-1:0] op_wdata;
  access_size_e      op_size;
  logic              exp_hit;
  logic [DATA_W-1:0] exp_data;
  int                wait_cycles;
  int                req_count;
  // Word of the last completed read
  logic              have_held;
  logic [DATA_W-1:0] held_rdata;

  // Same fill pattern as the memory model
  function automatic logic [31:0] initial_word(input int unsigned wa);
    return 32'h3c5a0000 ^ (wa * 32'h00010209);
  endfunction

  // ==========================================================================
  // Reference access, updates the model and predicts data and hit
  // ==========================================================================
  function automatic logic [DATA_W-1:0] reference_access(input logic [ADDR_W-1:0] addr,
    input logic write, input logic [DATA_W-1:0] wdata, input access_size_e size,
    output logic hit);
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    int unsigned        wa;
    logic [1:0]         lane;
    logic [3:0]         be;
    logic [31:0]        data;
    tag   = addr[ADDR_W-1 -: TAG_W];
    index = addr[OFFSET_W +: INDEX_W];
    wa    = addr[11:2];
    hit   = ref_valid[index] && (ref_tag[index] == tag);
    if (write)
    begin
      case (size)
        SIZE_BYTE:
        begin
          lane = addr[1:0];
          be   = 4'b0001 << lane;
        end
        SIZE_HALF:
        begin
          lane = {addr[1], 1'b0};
          be   = 4'b0011 << lane;
        end
        default:
        begin
          lane = 2'd0;
          be   = 4'b1111;
        end
      endcase
      data = wdata << {lane, 3'b000};
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
          ref_mem[wa][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    else if (!hit)
    begin
      // Read miss allocates the whole line
      ref_tag[index]   = tag;
      ref_valid[index] = 1'b1;
    end
    return ref_mem[wa];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
    input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h at %0t ns", name, expected, actual, $time);
    end
  endtask

  task automatic open_access();
    op_addr     = core_addr;
    op_write    = core_write;
    op_wdata    = core_wdata;
    op_size     = core_size;
    exp_data    = reference_access(core_addr, core_write, core_wdata, core_size, exp_hit);
    wait_cycles = 0;
    req_count   = 0;
    busy        = 1'b1;
  endtask

  task automatic check_request();
    if (op_write)
    begin
      check_value("mem_write", 1, mem_write);
      check_value("mem_addr", op_addr, mem_addr);
      check_value("mem_size", op_size, mem_size);
      check_value("mem_wdata", op_wdata, mem_wdata);
    end
    else
    begin
      // Fill reads walk the line from its base
      check_value("mem_write", 0, mem_write);
      check_value("mem_addr", {op_addr[ADDR_W-1:4], 4'b0000} + 4 * req_count, mem_addr);
      check_value("mem_size", SIZE_WORD, mem_size);
    end
    req_count++;
  endtask

  task automatic close_access();
    busy = 1'b0;
    ops_done++;
    if (op_write)
      check_value("mem_req count", 1, req_count);
    else
    begin
      check_value("core_rdata", exp_data, core_rdata);
      held_rdata = exp_data;
      have_held  = 1'b1;
      if (exp_hit)
      begin
        check_value("mem_req count", 0, req_count);
        check_value("core_wait cycles", 1, wait_cycles);
      end
      else
        check_value("mem_req count", 4, req_count);
    end
  endtask

  // ==========================================================================
  // Comparison process, sampled on the rising edge
  // ==========================================================================
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
        ref_mem[i] = initial_word(i);
      ref_valid   = '0;
      busy        = 1'b0;
      after_reset = 1'b1;
      have_held   = 1'b0;
      errors      = 0;
      checks      = 0;
      ops_done    = 0;
    end
    else
    begin
      if (after_reset)
      begin
        check_value("core_wait", 0, core_wait);
        check_value("mem_req", 0, mem_req);
        check_value("mem_write", 0, mem_write);
        after_reset = 1'b0;
      end
      if (busy)
      begin
        if (mem_req)
          check_request();
        if (core_wait)
        begin
          wait_cycles++;
          // Previous read data stays until this access ends
          if (have_held)
            check_value("core_rdata held", held_rdata, core_rdata);
        end
        else
          close_access();
      end
      else if (mem_req)
      begin
        errors++;
        $display("Memory request seen while no access was in progress at %0t ns", $time);
      end
      if (!busy && core_req && !core_wait)
        open_access();
    end
  end

endmodule

`default_nettype wire

// ==== tb_l1d_cache.sv ====
// Testbench top for the L1 data cache with clock, reset, memory model,
// LFSR stimulus, watchdog and the checker instance
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_cache import l1d_cache_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int MEM_WORDS       = 1024;
  localparam int N_DIRECTED      = 12;
  localparam int N_RANDOM        = 300;
  // Accept, lookup, four fills of up to 5 cycles, line write and slack
  localparam int WORST_OP_CYCLES = 26;
  localparam int TIMEOUT_NS      =
    ((N_DIRECTED + N_RANDOM) * WORST_OP_CYCLES + 100) * CLK_PERIOD;

  logic              clk;
  logic              rst;
  logic              core_req;
  logic [ADDR_W-1:0] core_addr;
  logic              core_write;
  logic [DATA_W-1:0] core_wdata;
  access_size_e      core_size;
  logic              core_wait;
  logic [DATA_W-1:0] core_rdata;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_wait;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_write;
  logic [DATA_W-1:0] mem_wdata;
  access_size_e      mem_size;

  int errors;
  int checks;
  int ops_done;
  int issued = 0;
  int failures;

  logic [DATA_W-1:0] mem_model [MEM_WORDS];
  int unsigned       wait_left = 0;
  logic              pending   = 1'b0;
  logic [15:0]       lfsr      = 16'd2916;

  l1d_cache l1d_cache_inst (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_addr  (core_addr),
    .core_write (core_write),
    .core_wdata (core_wdata),
    .core_size  (core_size),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_write  (mem_write),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size)
  );

  l1d_checker checker_inst (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_addr  (core_addr),
    .core_write (core_write),
    .core_wdata (core_wdata),
    .core_size  (core_size),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_write  (mem_write),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .errors     (errors),
    .checks     (checks),
    .ops_done   (ops_done)
  );

  // ==========================================================================
  // Random bits, x^16 + x^14 + x^13 + x^11 + 1
  // ==========================================================================
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] initial_word(input int unsigned wa);
    return 32'h3c5a0000 ^ (wa * 32'h00010209);
  endfunction

  // Tag from bit 10, index from bit 4, word select from bit 2
  function automatic logic [ADDR_W-1:0] make_addr(input int unsigned tag,
    input int unsigned index, input int unsigned wsel, input int unsigned lane);
    return (tag << 10) | (index << 4) | (wsel << 2) | lane;
  endfunction

  // ==========================================================================
  // Memory model, 0 to 3 wait cycles per transfer
  // ==========================================================================
  task automatic complete_transfer();
    int unsigned wa;
    logic [1:0]  lane;
    logic [3:0]  be;
    logic [31:0] data;
    wa = mem_addr[11:2];
    if (!mem_write)
      mem_rdata = mem_model[wa];
    else
    begin
      case (mem_size)
        SIZE_BYTE:
        begin
          lane = mem_addr[1:0];
          be   = 4'b0001 << lane;
        end
        SIZE_HALF:
        begin
          lane = {mem_addr[1], 1'b0};
          be   = 4'b0011 << lane;
        end
        default:
        begin
          lane = 2'd0;
          be   = 4'b1111;
        end
      endcase
      data = mem_wdata << {lane, 3'b000};
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
          mem_model[wa][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (rst)
      pending = 1'b0;
    else if (mem_req)
    begin
      wait_left = take_bits(2);
      pending   = 1'b1;
    end
    else if (pending && wait_left != 0)
    begin
      mem_wait  = 1'b1;
      wait_left = wait_left - 1;
    end
    else if (pending)
    begin
      mem_wait = 1'b0;
      pending  = 1'b0;
      complete_transfer();
    end
  end

  // ==========================================================================
  // Core stimulus
  // ==========================================================================
  // Called on a falling edge with core_wait low
  task automatic run_access(input logic [ADDR_W-1:0] addr, input logic write,
    input logic [DATA_W-1:0] wdata, input access_size_e size);
    core_req   = 1'b1;
    core_addr  = addr;
    core_write = write;
    core_wdata = wdata;
    core_size  = size;
    @(negedge clk);
    core_req = 1'b0;
    while (core_wait)
      @(negedge clk);
    issued++;
  endtask

  task automatic random_access();
    logic              write;
    int unsigned       tag;
    int unsigned       index;
    int unsigned       wsel;
    int unsigned       lane;
    logic [1:0]        sz;
    access_size_e      size;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    write = 1'(take_bits(1));
    // Four tags on four indexes keep conflicts frequent
    tag   = take_bits(2);
    index = take_bits(2);
    wsel  = take_bits(2);
    lane  = take_bits(2);
    sz    = 2'(take_bits(2));
    size  = (sz == 2'd0) ? SIZE_BYTE : (sz == 2'd1) ? SIZE_HALF : SIZE_WORD;
    addr  = make_addr(tag, index, wsel, lane);
    if (size == SIZE_HALF)
      addr[0] = 1'b0;
    else if (size == SIZE_WORD)
      addr[1:0] = 2'b00;
    wdata = take_bits(32);
    run_access(addr, write, wdata, size);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    rst        = 1'b1;
    core_req   = 1'b0;
    core_addr  = '0;
    core_write = 1'b0;
    core_wdata = '0;
    core_size  = SIZE_WORD;
    mem_rdata  = '0;
    mem_wait   = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem_model[i] = initial_word(i);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Cold miss, then hits in the same line
    run_access(make_addr(1, 2, 2, 0), 1'b0, '0, SIZE_WORD);
    run_access(make_addr(1, 2, 2, 0), 1'b0, '0, SIZE_WORD);
    run_access(make_addr(1, 2, 0, 0), 1'b0, '0, SIZE_WORD);
    // Partial writes to the resident line, then the merged word
    run_access(make_addr(1, 2, 2, 1), 1'b1, 32'h000000a5, SIZE_BYTE);
    run_access(make_addr(1, 2, 2, 2), 1'b1, 32'h00001234, SIZE_HALF);
    run_access(make_addr(1, 2, 2, 0), 1'b0, '0, SIZE_WORD);
    // Write miss without allocation
    run_access(make_addr(2, 5, 1, 0), 1'b1, 32'hdeadbeef, SIZE_WORD);
    run_access(make_addr(2, 5, 1, 0), 1'b0, '0, SIZE_WORD);
    // Conflicting tags at index 2 evict each other
    run_access(make_addr(3, 2, 3, 0), 1'b0, '0, SIZE_WORD);
    run_access(make_addr(1, 2, 2, 0), 1'b0, '0, SIZE_WORD);
    run_access(make_addr(3, 2, 3, 0), 1'b0, '0, SIZE_WORD);
    run_access(make_addr(0, 0, 1, 0), 1'b0, '0, SIZE_WORD);

    repeat (N_RANDOM) random_access();
    repeat (2) @(negedge clk);

    failures = errors;
    if (ops_done != issued)
    begin
      $display("Checker saw %0d completed accesses but %0d were issued", ops_done, issued);
      failures++;
    end
    $display("Checks: %0d, errors: %0d, accesses: %0d", checks, failures, issued);
    if (failures == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns with accesses still running", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== l1d_cache.f ====
l1d_cache_pkg.sv
bank_if.sv
l1d_ctrl.sv
l1d_word_bank.sv
l1d_lookup.sv
l1d_cache.sv
l1d_checker.sv
tb_l1d_cache.sv

// ==== Bender.yml ====
package:
  name: l1d_cache

sources:
  - files:
      - l1d_cache_pkg.sv
      - bank_if.sv
      - l1d_ctrl.sv
      - l1d_word_bank.sv
      - l1d_lookup.sv
      - l1d_cache.sv
  - target: test
    files:
      - l1d_checker.sv
      - tb_l1d_cache.sv

# Top modules: l1d_cache for synthesis, tb_l1d_cache for simulation
